// File: fm_guard_pkg.sv
`default_nettype none
//~~~~~~~~~~~~~~~~~~~~
// feature-map guard generator shared widths and lane types
//~~~~~~~~~~~~~~~~~~~~

package fm_guard_pkg;

    localparam int LANES      = 6;   // output channels handled in parallel
    localparam int PSUM_WIDTH = 32;  // signed partial sum
    localparam int REF_WIDTH  = 8;   // reference and output byte

    localparam int HALF_WIDTH = PSUM_WIDTH / 2;

    // one signed psum word
    typedef logic signed [PSUM_WIDTH-1:0] psum_t;

    // one output / reference byte
    typedef logic [REF_WIDTH-1:0] ref_byte_t;

    // the accumulated word is either one full signed value or,
    // in four-bit mode, two independent 16-bit halves
    typedef union packed {
        psum_t full;
        struct packed {
            logic signed [HALF_WIDTH-1:0] hi;
            logic signed [HALF_WIDTH-1:0] lo;
        } half;
    } psum_word_u;

    // lane arrays, lane 0 in the low bits
    typedef psum_t     [LANES-1:0] psum_lanes_t;
    typedef ref_byte_t [LANES-1:0] byte_lanes_t;

endpackage

`default_nettype wire

// File: psum_accum.sv
`timescale 1ns/1ps
`default_nettype none
//~~~~~~~~~~~~~~~~~~~~
// per-pixel channel accumulator
// adds bias on the first pass, stored sum afterwards, and steps the pixel counter
//~~~~~~~~~~~~~~~~~~~~

module psum_accum
    import fm_guard_pkg::*;
#(
    parameter  int MAX_PIX = 64,
    localparam int AW      = $clog2(MAX_PIX),      // pixel address
    localparam int NW      = $clog2(MAX_PIX + 1)   // pixel count, up to MAX_PIX
) (
    input  logic              clk,
    input  logic              rst_n,

    input  logic              psum_valid_i,  // one strobe per pixel
    input  logic              first_ch_i,    // first pass of the frame
    input  logic [NW-1:0]     num_pix_i,
    input  psum_lanes_t       psum_i,
    input  byte_lanes_t       bias_i,

    output psum_lanes_t       acc_o,         // new sum, combinational
    output logic [AW-1:0]     pix_addr_o,
    output logic              pix_last_o
);

    logic [AW-1:0] pix_cnt;
    psum_lanes_t   sum_mem [MAX_PIX];
    psum_lanes_t   stored;
    psum_lanes_t   base;

    assign pix_addr_o = pix_cnt;
    assign pix_last_o = (NW'(pix_cnt) == num_pix_i - 1'b1);

    // pixel counter, wraps after the last pixel of the frame
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pix_cnt <= '0;
        end else if (psum_valid_i) begin
            if (pix_last_o) begin
                pix_cnt <= '0;
            end else begin
                pix_cnt <= pix_cnt + 1'b1;
            end
        end
    end

    assign stored = sum_mem[pix_cnt];  // async read

    always_comb begin
        for (int l = 0; l < LANES; l++) begin
            // bias is an unsigned byte, zero extended
            base[l]  = first_ch_i ? psum_t'(PSUM_WIDTH'(bias_i[l])) : stored[l];
            acc_o[l] = psum_i[l] + base[l];
        end
    end

    // running sums, one word per lane per pixel
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int p = 0; p < MAX_PIX; p++) begin
                sum_mem[p] <= '0;
            end
        end else if (psum_valid_i) begin
            sum_mem[pix_cnt] <= acc_o;
        end
    end

    // counter must stay inside the frame whatever num_pix_i does between frames
    a_pix_in_frame: assert property (
        @(posedge clk) disable iff (!rst_n)
        psum_valid_i |-> (NW'(pix_cnt) < num_pix_i)
    ) else $error("pixel address %0d outside frame of %0d", pix_cnt, num_pix_i);

endmodule

`default_nettype wire

// File: ref_store.sv
`timescale 1ns/1ps
`default_nettype none
//~~~~~~~~~~~~~~~~~~~~
// per-pixel reference bytes for difference mode
//~~~~~~~~~~~~~~~~~~~~

module ref_store
    import fm_guard_pkg::*;
#(
    parameter  int MAX_PIX = 64,
    localparam int AW      = $clog2(MAX_PIX)
) (
    input  logic          clk,
    input  logic          rst_n,

    input  logic [AW-1:0] pix_addr_i,
    input  logic          first_frame_i,  // no valid history yet
    input  logic          ref_wr_i,
    input  byte_lanes_t   ref_new_i,

    output byte_lanes_t   ref_o
);

    byte_lanes_t   ref_mem [MAX_PIX];
    logic          wr_q;     // last cycle wrote
    logic [AW-1:0] addr_q;   // and where

    // first frame sees a zero reference
    assign ref_o = first_frame_i ? '0 : ref_mem[pix_addr_i];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int p = 0; p < MAX_PIX; p++) begin
                ref_mem[p] <= '0;
            end
        end else if (ref_wr_i) begin
            ref_mem[pix_addr_i] <= ref_new_i;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_q   <= 1'b0;
            addr_q <= '0;
        end else begin
            wr_q   <= ref_wr_i;
            addr_q <= pix_addr_i;
        end
    end

    // back-to-back writes must come from different pixels,
    // otherwise the pixel counter upstream did not advance
    a_no_double_write: assert property (
        @(posedge clk) disable iff (!rst_n)
        (ref_wr_i && wr_q) |-> (pix_addr_i != addr_q)
    ) else $error("reference written twice at pixel %0d", pix_addr_i);

endmodule

`default_nettype wire

// File: guard_write_back.sv
`timescale 1ns/1ps
`default_nettype none
//~~~~~~~~~~~~~~~~~~~~
// last-pass finish stage
// fold, diff, ReLU and saturation, guard bits and reference update
//~~~~~~~~~~~~~~~~~~~~

module guard_write_back
    import fm_guard_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,

    input  logic              psum_valid_i,
    input  logic              last_ch_i,
    input  logic              pix_last_i,
    input  logic              diff_mode_i,
    input  logic              bit_mode_i,   // four-bit mode, fold the halves
    input  psum_lanes_t       acc_i,
    input  byte_lanes_t       ref_i,

    output logic              ref_wr_o,
    output byte_lanes_t       ref_new_o,

    output byte_lanes_t       data_o,
    output logic [LANES-1:0]  guard_o,
    output logic              data_valid_o,
    output logic              frame_done_o
);

    localparam psum_t SAT_MAX = psum_t'((1 << REF_WIDTH) - 1);

    logic             finish;      // last-pass strobe
    byte_lanes_t      data_next;
    logic [LANES-1:0] guard_next;

    function automatic psum_t relu(input psum_t x);
        return x[PSUM_WIDTH-1] ? psum_t'(0) : x;
    endfunction

    // clamp into an unsigned byte, negative diffs end at zero
    function automatic ref_byte_t sat_byte(input psum_t x);
        if (x < 0) begin
            return '0;
        end else if (x > SAT_MAX) begin
            return '1;
        end
        return x[REF_WIDTH-1:0];
    endfunction

    assign finish = psum_valid_i & last_ch_i;

    for (genvar l = 0; l < LANES; l++) begin : g_lane
        psum_word_u word;
        psum_t      folded;
        psum_t      ref_ext;
        psum_t      ref_relu;
        psum_t      with_ref;
        psum_t      finished;

        assign word = acc_i[l];

        // halves are signed, the sum is sign extended to the full width
        assign folded = bit_mode_i ? word.half.hi + word.half.lo : word.full;

        assign ref_ext  = {{(PSUM_WIDTH - REF_WIDTH){ref_i[l][REF_WIDTH-1]}}, ref_i[l]};
        assign ref_relu = relu(ref_ext);
        assign with_ref = folded + ref_ext;

        assign finished = diff_mode_i ? relu(with_ref) - ref_relu : relu(folded);

        assign data_next[l]  = sat_byte(finished);
        assign guard_next[l] = (finished > 0);   // positive before the clamp
        assign ref_new_o[l]  = with_ref[REF_WIDTH-1:0];

        // guard comes from the unclamped value, so this covers the byte clamp
        a_guard_match: assert property (
            @(posedge clk) disable iff (!rst_n)
            data_valid_o |-> (guard_o[l] == (data_o[l] != '0))
        ) else $error("lane %0d guard %b for byte %0d", l, guard_o[l], data_o[l]);
    end

    // reference written on the strobe edge itself
    assign ref_wr_o = finish & diff_mode_i;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            data_valid_o <= 1'b0;
            frame_done_o <= 1'b0;
        end else begin
            data_valid_o <= finish;
            frame_done_o <= finish & pix_last_i;  // final pixel of the frame
        end
    end

    always_ff @(posedge clk) begin
        if (finish) begin
            data_o  <= data_next;
            guard_o <= guard_next;
        end
    end

endmodule

`default_nettype wire

// File: fm_guard_gen.sv
`timescale 1ns/1ps
`default_nettype none
//~~~~~~~~~~~~~~~~~~~~
// feature-map guard generator top
// accumulator and reference store feeding the guard write-back
//~~~~~~~~~~~~~~~~~~~~

module fm_guard_gen
    import fm_guard_pkg::*;
#(
    parameter  int MAX_PIX = 64,
    localparam int NW      = $clog2(MAX_PIX + 1)
) (
    input  logic              clk,
    input  logic              rst_n,

    // per-pixel psum stream
    input  logic              psum_valid_i,
    input  psum_lanes_t       psum_i,
    input  byte_lanes_t       bias_i,

    // pass and frame levels
    input  logic [NW-1:0]     num_pix_i,     // 1 to MAX_PIX
    input  logic              first_ch_i,
    input  logic              last_ch_i,
    input  logic              diff_mode_i,
    input  logic              bit_mode_i,
    input  logic              first_frame_i,

    output byte_lanes_t       data_o,
    output logic [LANES-1:0]  guard_o,
    output logic              data_valid_o,
    output logic              frame_done_o
);

    localparam int AW = $clog2(MAX_PIX);

    psum_lanes_t   acc;
    logic [AW-1:0] pix_addr;
    logic          pix_last;
    byte_lanes_t   ref_rd;
    logic          ref_wr;
    byte_lanes_t   ref_new;

    psum_accum #(
        .MAX_PIX      (MAX_PIX)
    ) u_psum_accum (
        .clk          (clk),
        .rst_n        (rst_n),
        .psum_valid_i (psum_valid_i),
        .first_ch_i   (first_ch_i),
        .num_pix_i    (num_pix_i),
        .psum_i       (psum_i),
        .bias_i       (bias_i),
        .acc_o        (acc),
        .pix_addr_o   (pix_addr),
        .pix_last_o   (pix_last)
    );

    // read and written at the same pixel address as the sum memory
    ref_store #(
        .MAX_PIX       (MAX_PIX)
    ) u_ref_store (
        .clk           (clk),
        .rst_n         (rst_n),
        .pix_addr_i    (pix_addr),
        .first_frame_i (first_frame_i),
        .ref_wr_i      (ref_wr),
        .ref_new_i     (ref_new),
        .ref_o         (ref_rd)
    );

    guard_write_back u_guard_write_back (
        .clk          (clk),
        .rst_n        (rst_n),
        .psum_valid_i (psum_valid_i),
        .last_ch_i    (last_ch_i),
        .pix_last_i   (pix_last),
        .diff_mode_i  (diff_mode_i),
        .bit_mode_i   (bit_mode_i),
        .acc_i        (acc),
        .ref_i        (ref_rd),
        .ref_wr_o     (ref_wr),
        .ref_new_o    (ref_new),
        .data_o       (data_o),
        .guard_o      (guard_o),
        .data_valid_o (data_valid_o),
        .frame_done_o (frame_done_o)
    );

endmodule

`default_nettype wire

// File: tb_fm_guard_checks.svh
//~~~~~~~~~~~~~~~~~~~~
// testbench model memories and compare tasks
//~~~~~~~~~~~~~~~~~~~~
`ifndef TB_FM_GUARD_CHECKS_SVH
`define TB_FM_GUARD_CHECKS_SVH

    // running sums and references as the rules predict them
    int          acc_model [MAX_PIX][LANES];
    byte_lanes_t ref_model [MAX_PIX];

    int          data_errors   = 0;
    int          guard_errors  = 0;
    int          strobe_errors = 0;

    // both memories come out of reset as zero
    task automatic clear_model();
        for (int p = 0; p < MAX_PIX; p++) begin
            ref_model[p] = '0;
            for (int l = 0; l < LANES; l++) begin
                acc_model[p][l] = 0;
            end
        end
    endtask

    task automatic check_bytes(input string name, input byte_lanes_t exp,
                               input byte_lanes_t act);
        if (act !== exp) begin
            data_errors++;
            $display("FAIL %s data_o expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_guard(input string name, input logic [LANES-1:0] exp,
                               input logic [LANES-1:0] act);
        if (act !== exp) begin
            guard_errors++;
            $display("FAIL %s guard_o expected %b actual %b", name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input string flag, input logic exp,
                              input logic act);
        if (act !== exp) begin
            strobe_errors++;
            $display("FAIL %s %s expected %b actual %b", name, flag, exp, act);
        end
    endtask

`endif

// File: tb_fm_guard_gen.sv
`timescale 1ns/1ps
`default_nettype none
//~~~~~~~~~~~~~~~~~~~~
// testbench for the feature-map guard generator
// plays a table of frames against a lane model
//~~~~~~~~~~~~~~~~~~~~

module tb_fm_guard_gen;
    import fm_guard_pkg::*;

    localparam int MAX_PIX = 64;
    localparam int NW      = $clog2(MAX_PIX + 1);
    localparam int N_ROWS  = 10;

    typedef struct {
        string       name;
        int          num_pix;
        int          chans;
        int          bound;   // psum magnitude, per half in four-bit mode
        byte_lanes_t bias;
        logic        diff;
        logic        bitm;
        logic        first;
    } row_t;

    logic             clk;
    logic             rst_n;
    logic             psum_valid_i;
    psum_lanes_t      psum_i;
    byte_lanes_t      bias_i;
    logic [NW-1:0]    num_pix_i;
    logic             first_ch_i;
    logic             last_ch_i;
    logic             diff_mode_i;
    logic             bit_mode_i;
    logic             first_frame_i;
    byte_lanes_t      data_o;
    logic [LANES-1:0] guard_o;
    logic             data_valid_o;
    logic             frame_done_o;

    row_t             rows [N_ROWS];
    int               cycles;
    int               cycle_limit;

    // what the outputs should show after the next edge
    logic             exp_valid;
    logic             exp_done;
    byte_lanes_t      exp_data;
    logic [LANES-1:0] exp_guard;
    string            exp_name;

    `include "tb_fm_guard_checks.svh"

    fm_guard_gen #(
        .MAX_PIX       (MAX_PIX)
    ) uut (
        .clk           (clk),
        .rst_n         (rst_n),
        .psum_valid_i  (psum_valid_i),
        .psum_i        (psum_i),
        .bias_i        (bias_i),
        .num_pix_i     (num_pix_i),
        .first_ch_i    (first_ch_i),
        .last_ch_i     (last_ch_i),
        .diff_mode_i   (diff_mode_i),
        .bit_mode_i    (bit_mode_i),
        .first_frame_i (first_frame_i),
        .data_o        (data_o),
        .guard_o       (guard_o),
        .data_valid_o  (data_valid_o),
        .frame_done_o  (frame_done_o)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > cycle_limit) begin
            $display("timeout: run still going after %0d cycles", cycle_limit);
            $display("test failed");
            $finish;
        end
    end

    task automatic load_rows();
        // name, pixels, channels, bound, bias, diff, four-bit, first frame
        rows[0] = '{"plain_one_ch", 4, 1, 60, 48'h0a_08_06_04_02_00, 1'b0, 1'b0, 1'b1};
        rows[1] = '{"plain_small", 16, 3, 60, 48'h05_00_30_01_ff_10, 1'b0, 1'b0, 1'b1};
        rows[2] = '{"plain_wide", 16, 4, 2000, 48'hff_80_7f_40_10_01, 1'b0, 1'b0, 1'b1};
        rows[3] = '{"plain_one_pix", 1, 3, 2000, 48'h00_00_00_00_00_00, 1'b0, 1'b0, 1'b1};
        rows[4] = '{"diff_frame0", 12, 3, 100, 48'h20_00_10_40_08_02, 1'b1, 1'b0, 1'b1};
        rows[5] = '{"diff_frame1", 12, 2, 100, 48'h03_60_00_11_22_33, 1'b1, 1'b0, 1'b0};
        rows[6] = '{"diff_frame2", 12, 4, 100, 48'h00_01_02_80_c0_e0, 1'b1, 1'b0, 1'b0};
        rows[7] = '{"fold_small", 10, 2, 40, 48'h00_04_08_0c_10_14, 1'b0, 1'b1, 1'b1};
        rows[8] = '{"fold_wide", 10, 3, 16383, 48'h7f_00_ff_01_80_02, 1'b0, 1'b1, 1'b1};
        rows[9] = '{"plain_full", 64, 2, 300, 48'hff_ff_ff_ff_ff_ff, 1'b0, 1'b0, 1'b1};
    endtask

    task automatic random_psums(input row_t r, output psum_lanes_t ps);
        int hi;
        int lo;
        for (int l = 0; l < LANES; l++) begin
            hi = int'($urandom_range(2 * r.bound)) - r.bound;
            lo = int'($urandom_range(2 * r.bound)) - r.bound;
            if (r.bitm) begin
                ps[l] = {hi[15:0], lo[15:0]};   // two signed halves
            end else begin
                ps[l] = lo;
            end
        end
    endtask

    // one pixel of one pass, updates the model and the expected byte lanes
    task automatic model_pixel(input row_t r, input int pix, input logic first_ch,
                               input logic last_ch, input psum_lanes_t ps);
        int                 acc;
        int                 v;
        int                 rv;
        int                 fin;
        logic signed [15:0] hi;
        logic signed [15:0] lo;
        logic signed [7:0]  rs;
        for (int l = 0; l < LANES; l++) begin
            if (first_ch) begin
                acc = ps[l] + {24'b0, r.bias[l]};
            end else begin
                acc = acc_model[pix][l] + ps[l];
            end
            acc_model[pix][l] = acc;
            if (last_ch) begin
                hi = acc[31:16];
                lo = acc[15:0];
                if (r.bitm) begin
                    v = hi + lo;
                end else begin
                    v = acc;
                end
                rs = r.first ? 8'sd0 : ref_model[pix][l];
                rv = rs;   // signed reference
                if (r.diff) begin
                    fin = ((v + rv) < 0 ? 0 : v + rv) - (rv < 0 ? 0 : rv);
                    ref_model[pix][l] = 8'(v + rv);
                end else begin
                    fin = v < 0 ? 0 : v;
                end
                if (fin > 255) begin
                    exp_data[l] = 8'hff;
                end else if (fin < 0) begin
                    exp_data[l] = 8'h00;
                end else begin
                    exp_data[l] = 8'(fin);
                end
                exp_guard[l] = (exp_data[l] != 8'h00);
            end
        end
    endtask

    // outputs are registered, look at them just after the edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
        check_flag(exp_name, "data_valid_o", exp_valid, data_valid_o);
        check_flag(exp_name, "frame_done_o", exp_done, frame_done_o);
        if (exp_valid) begin
            check_bytes(exp_name, exp_data, data_o);
            check_guard(exp_name, exp_guard, guard_o);
        end
    endtask

    task automatic play_frame(input row_t r);
        psum_lanes_t ps;
        logic        fc;
        logic        lc;
        num_pix_i     = NW'(r.num_pix);
        bias_i        = r.bias;
        diff_mode_i   = r.diff;
        bit_mode_i    = r.bitm;
        first_frame_i = r.first;
        for (int ch = 0; ch < r.chans; ch++) begin
            fc = (ch == 0);
            lc = (ch == r.chans - 1);
            for (int p = 0; p < r.num_pix; p++) begin
                random_psums(r, ps);
                psum_valid_i = 1'b1;   // strobes back to back
                psum_i       = ps;
                first_ch_i   = fc;
                last_ch_i    = lc;
                model_pixel(r, p, fc, lc, ps);
                exp_valid = lc;
                exp_done  = lc && (p == r.num_pix - 1);
                exp_name  = $sformatf("%s ch %0d px %0d", r.name, ch, p);
                next_cycle();
            end
        end
        psum_valid_i = 1'b0;
        exp_valid    = 1'b0;
        exp_done     = 1'b0;
        exp_name     = $sformatf("%s idle", r.name);
        next_cycle();
    endtask

    initial begin
        int total;
        void'($urandom(30801));
        clk           = 1'b0;
        rst_n         = 1'b0;
        psum_valid_i  = 1'b0;
        psum_i        = '0;
        bias_i        = '0;
        num_pix_i     = NW'(1);
        first_ch_i    = 1'b0;
        last_ch_i     = 1'b0;
        diff_mode_i   = 1'b0;
        bit_mode_i    = 1'b0;
        first_frame_i = 1'b1;
        exp_valid     = 1'b0;
        exp_done      = 1'b0;
        exp_data      = '0;
        exp_guard     = '0;
        exp_name      = "reset";
        cycles        = 0;
        clear_model();
        load_rows();
        cycle_limit = 100;
        for (int t = 0; t < N_ROWS; t++) begin
            cycle_limit += rows[t].num_pix * rows[t].chans;
        end

        repeat (3) @(posedge clk);
        #1;
        check_flag("reset", "data_valid_o", 1'b0, data_valid_o);
        check_flag("reset", "frame_done_o", 1'b0, frame_done_o);
        rst_n = 1'b1;
        next_cycle();
        next_cycle();

        for (int t = 0; t < N_ROWS; t++) begin
            play_frame(rows[t]);
        end

        total = data_errors + guard_errors + strobe_errors;
        $display("errors: data %0d guard %0d strobe %0d", data_errors, guard_errors,
                 strobe_errors);
        if (total == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: fm_guard_gen.f
+incdir+.
fm_guard_pkg.sv
psum_accum.sv
ref_store.sv
guard_write_back.sv
fm_guard_gen.sv
tb_fm_guard_gen.sv
